// ==== design/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // ------------------------------------------------------------
    // Architectural side
    // ------------------------------------------------------------
    localparam int ARCH_REGS = 32;
    localparam int AREG_W = 5;

    // ------------------------------------------------------------
    // Physical side
    // ------------------------------------------------------------
    // P0 is the constant zero register
    localparam int PHYS_REGS = 32;
    localparam int PREG_W = 5;

    // Tags P1..P16 are handed out by the free list
    localparam int FREE_DEPTH = 16;
    // Index bits plus one wrap bit
    localparam int FREE_PTR_W = 5;

    localparam int XLEN = 32;

    typedef logic [AREG_W-1:0] areg_t;
    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [XLEN-1:0] word_t;

endpackage

`default_nettype wire

// ==== design/spec_rat.sv ====
`timescale 1ns/1ns
`default_nettype none

module spec_rat (
    input  logic              clk,
    input  logic              rst_n,

    // Source lookups
    input  rename_pkg::areg_t rs1_i,
    input  rename_pkg::areg_t rs2_i,
    output rename_pkg::preg_t src1_preg_o,
    output rename_pkg::preg_t src2_preg_o,

    // Destination rename
    input  rename_pkg::areg_t rd_i,
    input  logic              wr_en_i,
    input  rename_pkg::preg_t wr_preg_i,

    // Rollback image from the committed table
    input  logic              restore_i,
    input  rename_pkg::preg_t restore_map_i [rename_pkg::ARCH_REGS]
);
    import rename_pkg::*;

    preg_t alias_table [ARCH_REGS];

    // Reads see the table before this cycle's rename write, so an
    // instruction reading its own rd gets the previous mapping
    always_comb begin
        src1_preg_o = alias_table[rs1_i];
        src2_preg_o = alias_table[rs2_i];
    end

    // ------------------------------------------------------------
    // Table update
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Every register starts out mapped to P0
            for (int i = 0; i < ARCH_REGS; i++) begin
                alias_table[i] <= '0;
            end
        end else if (restore_i) begin
            // Whole-table copy drops all speculative mappings
            for (int i = 0; i < ARCH_REGS; i++) begin
                alias_table[i] <= restore_map_i[i];
            end
        end else if (wr_en_i) begin
            alias_table[rd_i] <= wr_preg_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/arch_rat.sv ====
`timescale 1ns/1ns
`default_nettype none

module arch_rat (
    input  logic              clk,
    input  logic              rst_n,

    // Commit port
    input  logic              commit_valid_i,
    input  rename_pkg::areg_t commit_areg_i,
    input  rename_pkg::preg_t commit_preg_i,

    // Committed map, used as restore image on flush
    output rename_pkg::preg_t map_o [rename_pkg::ARCH_REGS]
);
    import rename_pkg::*;

    preg_t alias_table [ARCH_REGS];
    logic  wr_en;

    // Commits without a destination carry tag 0 and leave the map alone
    always_comb begin
        wr_en = commit_valid_i && (commit_preg_i != '0);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                alias_table[i] <= '0;
            end
        end else if (wr_en) begin
            alias_table[commit_areg_i] <= commit_preg_i;
        end
    end

    always_comb begin
        for (int i = 0; i < ARCH_REGS; i++) begin
            map_o[i] = alias_table[i];
        end
    end

endmodule

`default_nettype wire

// ==== design/phys_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module phys_regfile (
    input  logic              clk,
    input  logic              rst_n,

    // Write side, from commit
    input  logic              commit_valid_i,
    input  rename_pkg::preg_t commit_preg_i,
    input  rename_pkg::word_t commit_data_i,

    // New allocation marks its tag as pending
    input  logic              alloc_i,
    input  rename_pkg::preg_t alloc_tag_i,

    // Two source read ports
    input  rename_pkg::preg_t rd1_preg_i,
    input  rename_pkg::preg_t rd2_preg_i,
    output rename_pkg::word_t rd1_data_o,
    output rename_pkg::word_t rd2_data_o,
    output logic              rd1_ready_o,
    output logic              rd2_ready_o
);
    import rename_pkg::*;

    word_t                regs [PHYS_REGS];
    logic [PHYS_REGS-1:0] ready;
    logic                 wr_en;

    // P0 is never a write target
    always_comb begin
        wr_en = commit_valid_i && (commit_preg_i != '0);
    end

    always_comb begin
        rd1_data_o  = regs[rd1_preg_i];
        rd2_data_o  = regs[rd2_preg_i];
        rd1_ready_o = ready[rd1_preg_i];
        rd2_ready_o = ready[rd2_preg_i];
    end

    // ------------------------------------------------------------
    // Data storage
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[commit_preg_i] <= commit_data_i;
        end
    end

    // ------------------------------------------------------------
    // Ready scoreboard
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready <= '1;
        end else begin
            // Commit is applied last so it wins on a tag collision
            if (alloc_i && (alloc_tag_i != '0)) begin
                ready[alloc_tag_i] <= 1'b0;
            end
            if (wr_en) begin
                ready[commit_preg_i] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/free_list_ctr.sv ====
`timescale 1ns/1ns
`default_nettype none

module free_list_ctr (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alloc_i,
    input  logic              free_i,
    input  logic              flush_i,
    output rename_pkg::preg_t alloc_tag_o,
    output logic              exhausted_o
);
    import rename_pkg::*;

    localparam int MSB = FREE_PTR_W - 1;

    logic [FREE_PTR_W-1:0] alloc_ptr;
    logic [FREE_PTR_W-1:0] free_ptr;
    logic [FREE_PTR_W-1:0] free_ptr_next;

    // Tags come out in ring order starting at P1
    always_comb begin
        alloc_tag_o = preg_t'(alloc_ptr % FREE_DEPTH) + preg_t'(1);
    end

    // Same index with opposite wrap bits means all tags are out
    always_comb begin
        exhausted_o = (alloc_ptr[MSB] != free_ptr[MSB]) &&
                      (alloc_ptr[MSB-1:0] == free_ptr[MSB-1:0]);
    end

    always_comb begin
        free_ptr_next = free_ptr;
        if (free_i) begin
            free_ptr_next = free_ptr + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Pointer registers
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_ptr <= '0;
        end else begin
            free_ptr <= free_ptr_next;
        end
    end

    // Flush takes back everything not yet committed, including
    // a commit that lands in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alloc_ptr <= '0;
        end else if (flush_i) begin
            alloc_ptr <= free_ptr_next;
        end else if (alloc_i) begin
            alloc_ptr <= alloc_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/rename_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module rename_stage (
    input  logic              clk,
    input  logic              rst_n,

    // Dispatch side
    input  logic              dispatch_valid_i,
    input  rename_pkg::areg_t rs1_i,
    input  rename_pkg::areg_t rs2_i,
    input  rename_pkg::areg_t rd_i,
    input  rename_pkg::word_t imm_i,
    input  logic              src_imm_i,
    output logic              dispatch_ready_o,

    // Consumer side
    input  logic              stall_i,
    input  logic              flush_i,
    output logic              ren_valid_o,
    output rename_pkg::preg_t rd_tag_o,
    output rename_pkg::preg_t rs1_tag_o,
    output rename_pkg::word_t rs1_data_o,
    output rename_pkg::preg_t rs2_tag_o,
    output rename_pkg::word_t rs2_data_o,

    // Commit, for the bypass
    input  logic              commit_valid_i,
    input  rename_pkg::preg_t commit_preg_i,
    input  rename_pkg::word_t commit_data_i,

    // Lookups from tables, register file and free list
    input  rename_pkg::preg_t src1_preg_i,
    input  rename_pkg::preg_t src2_preg_i,
    input  logic              src1_ready_i,
    input  logic              src2_ready_i,
    input  rename_pkg::word_t src1_data_i,
    input  rename_pkg::word_t src2_data_i,
    input  rename_pkg::preg_t alloc_tag_i,
    input  logic              exhausted_i,

    // Buffered instruction fields and the allocate strobe
    output logic              alloc_o,
    output rename_pkg::areg_t buf_rs1_o,
    output rename_pkg::areg_t buf_rs2_o,
    output rename_pkg::areg_t buf_rd_o
);
    import rename_pkg::*;

    logic  buf_valid;
    areg_t buf_rs1;
    areg_t buf_rs2;
    areg_t buf_rd;
    word_t buf_imm;
    logic  buf_src_imm;
    logic  fire;
    logic  writes_rd;
    logic  hit1;
    logic  hit2;

    // ------------------------------------------------------------
    // Fire and ready control
    // ------------------------------------------------------------
    always_comb begin
        writes_rd = (buf_rd != '0);
        fire = buf_valid && !stall_i && !flush_i && (!writes_rd || !exhausted_i);
        // Nothing is accepted while a flush empties the buffer
        dispatch_ready_o = !flush_i && (!buf_valid || fire);
        ren_valid_o = fire;
        alloc_o = fire && writes_rd;
    end

    // ------------------------------------------------------------
    // Single-entry dispatch buffer
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid <= 1'b0;
        end else if (flush_i) begin
            buf_valid <= 1'b0;
        end else if (dispatch_ready_o) begin
            buf_valid <= dispatch_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_ready_o && dispatch_valid_i) begin
            buf_rs1     <= rs1_i;
            buf_rs2     <= rs2_i;
            buf_rd      <= rd_i;
            buf_imm     <= imm_i;
            buf_src_imm <= src_imm_i;
        end
    end

    always_comb begin
        buf_rs1_o = buf_rs1;
        buf_rs2_o = buf_rs2;
        buf_rd_o  = buf_rd;
    end

    // ------------------------------------------------------------
    // Commit bypass and operand muxes
    // ------------------------------------------------------------
    always_comb begin
        hit1 = commit_valid_i && (commit_preg_i != '0) && (src1_preg_i == commit_preg_i);
        hit2 = commit_valid_i && (commit_preg_i != '0) && (src2_preg_i == commit_preg_i);
    end

    // Tag 0 tells the consumer the data field is valid
    always_comb begin
        rd_tag_o = writes_rd ? alloc_tag_i : '0;

        if ((buf_rs1 == '0) || src1_ready_i || hit1) begin
            rs1_tag_o = '0;
        end else begin
            rs1_tag_o = src1_preg_i;
        end
        if ((buf_rs1 == '0)) begin
            rs1_data_o = '0;
        end else if (hit1) begin
            rs1_data_o = commit_data_i;
        end else begin
            rs1_data_o = src1_data_i;
        end

        if (buf_src_imm || (buf_rs2 == '0) || src2_ready_i || hit2) begin
            rs2_tag_o = '0;
        end else begin
            rs2_tag_o = src2_preg_i;
        end
        if (buf_src_imm) begin
            rs2_data_o = buf_imm;
        end else if (buf_rs2 == '0) begin
            rs2_data_o = '0;
        end else if (hit2) begin
            rs2_data_o = commit_data_i;
        end else begin
            rs2_data_o = src2_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/rename_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rename_top (
    input  logic              clk,
    input  logic              rst_n,

    // Dispatch
    input  logic              dispatch_valid_i,
    input  rename_pkg::areg_t rs1_i,
    input  rename_pkg::areg_t rs2_i,
    input  rename_pkg::areg_t rd_i,
    input  rename_pkg::word_t imm_i,
    input  logic              src_imm_i,
    output logic              dispatch_ready_o,

    // Consumer
    input  logic              stall_i,
    output logic              ren_valid_o,
    output rename_pkg::preg_t rd_tag_o,
    output rename_pkg::preg_t rs1_tag_o,
    output rename_pkg::word_t rs1_data_o,
    output rename_pkg::preg_t rs2_tag_o,
    output rename_pkg::word_t rs2_data_o,

    // Commit and flush
    input  logic              commit_valid_i,
    input  rename_pkg::areg_t commit_areg_i,
    input  rename_pkg::preg_t commit_preg_i,
    input  rename_pkg::word_t commit_data_i,
    input  logic              flush_i
);
    import rename_pkg::*;

    logic  alloc;
    preg_t alloc_tag;
    logic  exhausted;
    logic  commit_free;
    areg_t buf_rs1;
    areg_t buf_rs2;
    areg_t buf_rd;
    preg_t src1_preg;
    preg_t src2_preg;
    logic  src1_ready;
    logic  src2_ready;
    word_t src1_data;
    word_t src2_data;
    preg_t arch_map [ARCH_REGS];

    // Only commits that wrote a register return a tag
    assign commit_free = commit_valid_i && (commit_preg_i != '0);

    rename_stage u_stage (
        .clk(clk), .rst_n(rst_n),
        .dispatch_valid_i(dispatch_valid_i),
        .rs1_i(rs1_i), .rs2_i(rs2_i), .rd_i(rd_i),
        .imm_i(imm_i), .src_imm_i(src_imm_i),
        .dispatch_ready_o(dispatch_ready_o),
        .stall_i(stall_i), .flush_i(flush_i),
        .ren_valid_o(ren_valid_o), .rd_tag_o(rd_tag_o),
        .rs1_tag_o(rs1_tag_o), .rs1_data_o(rs1_data_o),
        .rs2_tag_o(rs2_tag_o), .rs2_data_o(rs2_data_o),
        .commit_valid_i(commit_valid_i),
        .commit_preg_i(commit_preg_i), .commit_data_i(commit_data_i),
        .src1_preg_i(src1_preg), .src2_preg_i(src2_preg),
        .src1_ready_i(src1_ready), .src2_ready_i(src2_ready),
        .src1_data_i(src1_data), .src2_data_i(src2_data),
        .alloc_tag_i(alloc_tag), .exhausted_i(exhausted),
        .alloc_o(alloc),
        .buf_rs1_o(buf_rs1), .buf_rs2_o(buf_rs2), .buf_rd_o(buf_rd)
    );

    spec_rat u_spec_rat (
        .clk(clk), .rst_n(rst_n),
        .rs1_i(buf_rs1), .rs2_i(buf_rs2),
        .src1_preg_o(src1_preg), .src2_preg_o(src2_preg),
        .rd_i(buf_rd), .wr_en_i(alloc), .wr_preg_i(alloc_tag),
        .restore_i(flush_i), .restore_map_i(arch_map)
    );

    arch_rat u_arch_rat (
        .clk(clk), .rst_n(rst_n),
        .commit_valid_i(commit_valid_i),
        .commit_areg_i(commit_areg_i), .commit_preg_i(commit_preg_i),
        .map_o(arch_map)
    );

    phys_regfile u_prf (
        .clk(clk), .rst_n(rst_n),
        .commit_valid_i(commit_valid_i),
        .commit_preg_i(commit_preg_i), .commit_data_i(commit_data_i),
        .alloc_i(alloc), .alloc_tag_i(alloc_tag),
        .rd1_preg_i(src1_preg), .rd2_preg_i(src2_preg),
        .rd1_data_o(src1_data), .rd2_data_o(src2_data),
        .rd1_ready_o(src1_ready), .rd2_ready_o(src2_ready)
    );

    free_list_ctr u_free_list (
        .clk(clk), .rst_n(rst_n),
        .alloc_i(alloc), .free_i(commit_free), .flush_i(flush_i),
        .alloc_tag_o(alloc_tag), .exhausted_o(exhausted)
    );

endmodule

`default_nettype wire

// ==== sim/rename_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module rename_assertions (
    input logic clk,
    input logic rst_n,
    input logic flush_i,
    input logic stall_i,
    input logic ren_valid_i,
    input logic dispatch_ready_i
);

    // Flushed work never reaches the consumer
    property no_valid_after_flush;
        @(posedge clk) disable iff (!rst_n) flush_i |=> !ren_valid_i;
    endproperty

    property no_valid_under_stall;
        @(posedge clk) disable iff (!rst_n) stall_i |-> !ren_valid_i;
    endproperty

    // Empty buffer right out of reset
    property ready_after_reset;
        @(posedge clk) $rose(rst_n) |-> dispatch_ready_i;
    endproperty

    a_no_valid_after_flush: assert property (no_valid_after_flush)
        else $error("ren_valid_o high in the cycle after a flush");

    a_no_valid_under_stall: assert property (no_valid_under_stall)
        else $error("ren_valid_o high while stall_i is high");

    a_ready_after_reset: assert property (ready_after_reset)
        else $error("dispatch_ready_o low in the first cycle after reset");

endmodule

bind rename_top rename_assertions u_assertions (
    .clk(clk),
    .rst_n(rst_n),
    .flush_i(flush_i),
    .stall_i(stall_i),
    .ren_valid_i(ren_valid_o),
    .dispatch_ready_i(dispatch_ready_o)
);

`default_nettype wire

// ==== sim/rename_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rename_tb;
    import rename_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLES_PER_VECTOR = 40;

    logic  clk;
    logic  rst_n;
    logic  dispatch_valid_i;
    areg_t rs1_i;
    areg_t rs2_i;
    areg_t rd_i;
    word_t imm_i;
    logic  src_imm_i;
    logic  dispatch_ready_o;
    logic  stall_i;
    logic  ren_valid_o;
    preg_t rd_tag_o;
    preg_t rs1_tag_o;
    word_t rs1_data_o;
    preg_t rs2_tag_o;
    word_t rs2_data_o;
    logic  commit_valid_i;
    areg_t commit_areg_i;
    preg_t commit_preg_i;
    word_t commit_data_i;
    logic  flush_i;

    int    seed = 32'he663;
    string lines[$];
    int    line_nos[$];
    int    error_cnt = 0;
    int    check_cnt = 0;
    int    test_cnt = 0;
    int    cycle_cnt = 0;
    int    cycle_limit = 0;
    int    stall_pending = 0;
    bit    test_bad;
    logic  flush_prev = 1'b0;

    rename_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Run limit grows with the number of vectors
    initial begin
        wait (cycle_limit != 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("TB FAILED");
        $finish;
    end

    // Consumer rules checked on pre-edge values
    always @(posedge clk) begin
        if (rst_n && ren_valid_o && (stall_i || flush_prev)) begin
            $display("ren_valid_o high under stall or right after a flush");
            error_cnt++;
        end
        flush_prev = flush_i;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_cnt++;
        if (expected !== actual) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            error_cnt++;
            test_bad = 1'b1;
        end
    endtask

    // Idle inputs carry noise that the DUT has to ignore
    task automatic drive_idle();
        dispatch_valid_i = 1'b0;
        rs1_i = areg_t'($random(seed));
        rs2_i = areg_t'($random(seed));
        rd_i = areg_t'($random(seed));
        imm_i = word_t'($random(seed));
        src_imm_i = 1'b0;
        stall_i = 1'b0;
        flush_i = 1'b0;
        commit_valid_i = 1'b0;
        commit_areg_i = areg_t'($random(seed));
        commit_preg_i = preg_t'($random(seed));
        commit_data_i = word_t'($random(seed));
    endtask

    task automatic read_vectors();
        int    fd;
        int    line_no;
        string line;
        fd = $fopen("sim/rename_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open sim/rename_vectors.txt");
            error_cnt++;
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0) begin
                line_no++;
                if ((line.len() > 1) && (line.getc(0) != "#")) begin
                    lines.push_back(line);
                    line_nos.push_back(line_no);
                end
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------------
    // Commands
    // ------------------------------------------------------------
    task automatic dispatch_and_check(input string line, input int line_no);
        logic [31:0] rs1, rs2, rd, imm, simm, cv, cdly, careg, cpreg, cdata;
        logic [31:0] lat, erd, ers1, ed1, ers2, ed2;
        int          n;
        int          k;
        bit          fired;
        string       name;
        n = $sscanf(line, "D %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    rs1, rs2, rd, imm, simm, cv, cdly, careg, cpreg, cdata,
                    lat, erd, ers1, ed1, ers2, ed2);
        if (n != 16) begin
            $display("Line %0d: malformed dispatch vector", line_no);
            error_cnt++;
            test_bad = 1'b1;
            return;
        end
        name = $sformatf("line %0d", line_no);
        @(negedge clk);
        drive_idle();
        dispatch_valid_i = 1'b1;
        rs1_i = rs1[AREG_W-1:0];
        rs2_i = rs2[AREG_W-1:0];
        rd_i = rd[AREG_W-1:0];
        imm_i = imm;
        src_imm_i = simm[0];
        #1;
        while (!dispatch_ready_o) begin
            @(negedge clk);
            #1;
        end
        // Count buffer cycles until the instruction fires
        fired = 1'b0;
        k = 0;
        while (!fired) begin
            @(negedge clk);
            drive_idle();
            stall_i = (k < stall_pending);
            if (cv[0] && (k == cdly)) begin
                commit_valid_i = 1'b1;
                commit_areg_i = careg[AREG_W-1:0];
                commit_preg_i = cpreg[PREG_W-1:0];
                commit_data_i = cdata;
            end
            #1;
            // A held buffer blocks dispatch until its fire cycle
            check_value({name, " dispatch_ready"}, 32'(k == lat), 32'(dispatch_ready_o));
            if (ren_valid_o) begin
                fired = 1'b1;
            end else begin
                k++;
            end
        end
        stall_pending = 0;
        check_value({name, " latency"}, lat, k);
        check_value({name, " rd_tag"}, erd, 32'(rd_tag_o));
        check_value({name, " rs1_tag"}, ers1, 32'(rs1_tag_o));
        if (ers1 == 0) begin
            check_value({name, " rs1_data"}, ed1, rs1_data_o);
        end
        check_value({name, " rs2_tag"}, ers2, 32'(rs2_tag_o));
        if (ers2 == 0) begin
            check_value({name, " rs2_data"}, ed2, rs2_data_o);
        end
    endtask

    task automatic apply_commit(input string line, input int line_no);
        logic [31:0] areg, preg, data;
        if ($sscanf(line, "C %h %h %h", areg, preg, data) != 3) begin
            $display("Line %0d: malformed commit vector", line_no);
            error_cnt++;
            test_bad = 1'b1;
            return;
        end
        @(negedge clk);
        drive_idle();
        commit_valid_i = 1'b1;
        commit_areg_i = areg[AREG_W-1:0];
        commit_preg_i = preg[PREG_W-1:0];
        commit_data_i = data;
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        byte c;
        int  n;
        rst_n = 1'b0;
        drive_idle();
        read_vectors();
        cycle_limit = RESET_CYCLES + (lines.size() + 1) * CYCLES_PER_VECTOR;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        #1;
        // Empty buffer out of reset
        check_value("reset dispatch_ready", 32'd1, 32'(dispatch_ready_o));
        check_value("reset ren_valid", 32'd0, 32'(ren_valid_o));
        foreach (lines[i]) begin
            test_bad = 1'b0;
            c = lines[i].getc(0);
            case (c)
                "D": dispatch_and_check(lines[i], line_nos[i]);
                "C": apply_commit(lines[i], line_nos[i]);
                "F": begin
                    @(negedge clk);
                    drive_idle();
                    flush_i = 1'b1;
                end
                "S": begin
                    n = $sscanf(lines[i], "S %h", stall_pending);
                    if (n != 1) begin
                        $display("Line %0d: malformed stall vector", line_nos[i]);
                        error_cnt++;
                        test_bad = 1'b1;
                    end
                end
                default: begin
                    $display("Line %0d: unknown command", line_nos[i]);
                    error_cnt++;
                    test_bad = 1'b1;
                end
            endcase
            test_cnt++;
            $display("line %0d %c %s", line_nos[i], c, test_bad ? "mismatch" : "ok");
        end
        @(negedge clk);
        drive_idle();
        repeat (4) @(negedge clk);
        if (test_cnt == 0) begin
            $display("No vectors were run");
            error_cnt++;
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/rename_pkg.sv
design/spec_rat.sv
design/arch_rat.sv
design/phys_regfile.sv
design/free_list_ctr.sv
design/rename_stage.sv
design/rename_top.sv
sim/rename_assertions.sv
sim/rename_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= rename_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := TB FAILED
PASS_MSG  := TB PASSED

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
VECTORS := sim/rename_vectors.txt

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN) $(VECTORS)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || \
	   ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/rename_vectors.txt ====
# D rs1 rs2 rd imm simm  cv cdly careg cpreg cdata  lat rd_tag rs1_tag rs1_data rs2_tag rs2_data
# C areg preg data, F flush, S n stalls the next dispatch for n cycles; all fields hex
# Tags handed out in order after reset
D 01 02 01 00000000 0  0 0 00 00 00000000  0 01 00 00000000 00 00000000
D 03 04 02 00000000 0  0 0 00 00 00000000  0 02 00 00000000 00 00000000
D 05 00 03 00000000 0  0 0 00 00 00000000  0 03 00 00000000 00 00000000
# Sources of uncommitted destinations
D 01 02 04 00000000 0  0 0 00 00 00000000  0 04 01 00000000 02 00000000
# Commit, then same-cycle bypass on each source
C 01 01 11111111
D 01 04 05 00000000 0  0 0 00 00 00000000  0 05 00 11111111 04 00000000
D 02 03 06 00000000 0  1 0 02 02 22222222  0 06 00 22222222 03 00000000
D 04 03 00 00000000 0  1 0 03 03 33333333  0 00 04 00000000 00 33333333
# Immediate operand and x0 destination
D 00 05 07 deadbeef 1  0 0 00 00 00000000  0 07 00 00000000 00 deadbeef
D 07 00 00 00000000 0  0 0 00 00 00000000  0 00 07 00000000 00 00000000
D 00 00 08 00000000 0  0 0 00 00 00000000  0 08 00 00000000 00 00000000
S 3
D 05 06 09 00000000 0  0 0 00 00 00000000  3 09 05 00000000 06 00000000
# Fill the free list, tags wrap after 16
D 00 00 0a 00000000 0  0 0 00 00 00000000  0 0a 00 00000000 00 00000000
D 00 00 0b 00000000 0  0 0 00 00 00000000  0 0b 00 00000000 00 00000000
D 00 00 0c 00000000 0  0 0 00 00 00000000  0 0c 00 00000000 00 00000000
D 00 00 0d 00000000 0  0 0 00 00 00000000  0 0d 00 00000000 00 00000000
D 00 00 0e 00000000 0  0 0 00 00 00000000  0 0e 00 00000000 00 00000000
D 00 00 0f 00000000 0  0 0 00 00 00000000  0 0f 00 00000000 00 00000000
D 00 00 10 00000000 0  0 0 00 00 00000000  0 10 00 00000000 00 00000000
D 00 00 11 00000000 0  0 0 00 00 00000000  0 01 00 00000000 00 00000000
D 00 00 12 00000000 0  0 0 00 00 00000000  0 02 00 00000000 00 00000000
D 00 00 13 00000000 0  0 0 00 00 00000000  0 03 00 00000000 00 00000000
# Exhausted until the commit in buffer cycle 3 frees a tag
D 11 04 14 00000000 0  1 3 04 04 44444444  4 04 01 00000000 00 44444444
C 05 05 55555555
C 06 06 66666666
# Flush back to the committed map
F
D 05 06 07 00000000 0  0 0 00 00 00000000  0 07 00 55555555 00 66666666
D 14 07 08 00000000 0  0 0 00 00 00000000  0 08 00 00000000 07 00000000
C 07 07 77777777
D 07 00 00 00000000 0  0 0 00 00 00000000  0 00 00 77777777 00 00000000
# Stall, then a commit bypassed in the fire cycle
S 2
D 08 00 09 00000000 0  1 2 08 08 88888888  2 09 00 88888888 00 00000000
